// ==== hw/score_pkg.sv ====
package score_pkg;

  // Spin kind reported by the host with each lock
  typedef enum logic [2:0] {
    SPIN_NONE   = 3'd0,
    SPIN_T      = 3'd1,
    SPIN_T_MINI = 3'd2,
    SPIN_S      = 3'd3,
    SPIN_Z      = 3'd4,
    SPIN_J      = 3'd5,
    SPIN_L      = 3'd6,
    SPIN_I      = 3'd7
  } spin_t;

  localparam int LINES_W         = 3;
  localparam int MAX_LINES       = 4;
  localparam int TOTAL_LINES_W   = 8;
  localparam int STREAK_W        = 4;
  localparam int STREAK_MAX      = 15;
  localparam int LEVEL_W         = 4;
  localparam int LEVEL_MAX       = 15;
  localparam int LINES_PER_LEVEL = 10;

  localparam int POINTS_W          = 16;
  localparam int BCD_DIGITS_POINTS = 5;
  localparam int SCORE_DIGITS      = 8; // 32-bit score

  // ====================
  // Gravity, frames per row by level
  localparam int FRAMES_W = 6;
  localparam logic [FRAMES_W-1:0] DROP_FRAMES [LEVEL_MAX+1] = '{
    6'd40, 6'd37, 6'd34, 6'd30, 6'd26, 6'd21, 6'd15, 6'd12,
    6'd8,  6'd6,  6'd5,  6'd5,  6'd5,  6'd4,  6'd3,  6'd2
  };

  // ====================
  // Point tables, indexed by line count 0..4
  localparam logic [POINTS_W-1:0] BASE_POINTS [MAX_LINES+1] = '{0, 40, 100, 300, 1200};
  localparam int STREAK_STEP = 100;
  localparam int STREAK_CAP  = 500;
  localparam logic [POINTS_W-1:0] T_SPIN_BONUS    [MAX_LINES+1] = '{400, 800, 1200, 1600, 0};
  localparam logic [POINTS_W-1:0] MINI_SPIN_BONUS [MAX_LINES+1] = '{100, 200, 0, 0, 0};
  localparam logic [POINTS_W-1:0] SZJL_SPIN_BONUS [MAX_LINES+1] = '{0, 400, 800, 1200, 0};
  localparam logic [POINTS_W-1:0] I_SPIN_BONUS    [MAX_LINES+1] = '{0, 400, 800, 0, 1600};

endpackage

// ==== hw/apb_pkg.sv ====
package apb_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  typedef enum logic [ADDR_W-1:0] {
    REG_EVENT = 8'h00, // write only
    REG_SCORE = 8'h04,
    REG_LINES = 8'h08,
    REG_LEVEL = 8'h0C,
    REG_FLAGS = 8'h10,
    REG_CLEAR = 8'h14  // write only
  } reg_addr_t;

  // Field offsets inside the registers
  localparam int EV_LINES_LSB  = 0;
  localparam int EV_SPIN_LSB   = 4;
  localparam int LN_TOTAL_LSB  = 0;
  localparam int LN_STREAK_LSB = 8;
  localparam int LV_LEVEL_LSB  = 0;
  localparam int LV_FRAMES_LSB = 8;
  localparam int FL_SPIN_LSB   = 0;
  localparam int FL_TETRIS_BIT = 4;

endpackage

// ==== hw/lock_apb_regs.sv ====
module lock_apb_regs import score_pkg::*, apb_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [ADDR_W-1:0]         paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [DATA_W-1:0]         pwdata,
  output logic [DATA_W-1:0]         prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic [4*SCORE_DIGITS-1:0] score,
  input  logic [TOTAL_LINES_W-1:0]  total_lines,
  input  logic [STREAK_W-1:0]       streak,
  input  logic [LEVEL_W-1:0]        level,
  input  logic [FRAMES_W-1:0]       drop_frames,
  input  spin_t                     last_spin,
  input  logic                      tetris,
  output logic                      event_valid,
  output logic [LINES_W-1:0]        event_lines,
  output spin_t                     event_spin,
  output logic                      clear
);

  logic              access;
  logic              bad;
  logic [DATA_W-1:0] rd_data;
  logic [LINES_W-1:0] wr_lines;
  logic [2:0]        wr_spin;
  logic              ev_hit;
  logic              clr_hit;

  assign access   = psel & penable;
  assign pready   = 1'b1; // No wait states
  assign wr_lines = pwdata[EV_LINES_LSB +: LINES_W];
  assign wr_spin  = pwdata[EV_SPIN_LSB +: 3];

  // ====================
  // Decode and read mux
  always_comb begin
    bad     = 1'b0;
    rd_data = '0;
    case (paddr)
      REG_EVENT: bad = !pwrite || (wr_lines > MAX_LINES);
      REG_SCORE: begin
        bad     = pwrite;
        rd_data = score;
      end
      REG_LINES: begin
        bad = pwrite;
        rd_data[LN_TOTAL_LSB +: TOTAL_LINES_W] = total_lines;
        rd_data[LN_STREAK_LSB +: STREAK_W]     = streak;
      end
      REG_LEVEL: begin
        bad = pwrite;
        rd_data[LV_LEVEL_LSB +: LEVEL_W]   = level;
        rd_data[LV_FRAMES_LSB +: FRAMES_W] = drop_frames;
      end
      REG_FLAGS: begin
        bad = pwrite;
        rd_data[FL_SPIN_LSB +: 3]   = last_spin;
        rd_data[FL_TETRIS_BIT]      = tetris;
      end
      REG_CLEAR: bad = !pwrite;
      default:   bad = 1'b1; // Unmapped
    endcase
  end

  assign pslverr = access & bad;
  assign prdata  = (access && !pwrite) ? rd_data : '0;
  assign ev_hit  = access && pwrite && !bad && (paddr == REG_EVENT);
  assign clr_hit = access && pwrite && !bad && (paddr == REG_CLEAR);

  // One-cycle pulses toward the datapath
  always_ff @(posedge clk) begin
    if (rst) begin
      event_valid <= 1'b0;
      clear       <= 1'b0;
    end else begin
      event_valid <= ev_hit;
      clear       <= clr_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (ev_hit) begin
      event_lines <= wr_lines;
      event_spin  <= spin_t'(wr_spin);
    end
  end

endmodule

// ==== hw/points_calc.sv ====
module points_calc import score_pkg::*; (
  input  logic [LINES_W-1:0]  event_lines,
  input  spin_t               event_spin,
  input  logic [LEVEL_W-1:0]  level,
  input  logic [STREAK_W-1:0] streak,
  output logic [POINTS_W-1:0] points
);

  logic [LEVEL_W:0]    mult;
  logic [LINES_W-1:0]  idx;
  logic [POINTS_W-1:0] base;
  logic [POINTS_W-1:0] streak_raw;
  logic [POINTS_W-1:0] streak_bonus;
  logic [POINTS_W-1:0] spin_raw;

  assign mult = {1'b0, level} + 1'b1; // 1..16
  assign idx  = (event_lines > MAX_LINES) ? '0 : event_lines;

  // ====================
  // Base and streak
  always_comb begin
    base       = BASE_POINTS[idx] * POINTS_W'(mult);
    streak_raw = POINTS_W'(streak) * POINTS_W'(STREAK_STEP);
    if (event_lines != '0 && streak != '0) begin
      if (streak_raw > POINTS_W'(STREAK_CAP))
        streak_bonus = POINTS_W'(STREAK_CAP);
      else
        streak_bonus = streak_raw;
    end else begin
      streak_bonus = '0;
    end
  end

  // ====================
  // Spin bonus before level scaling
  always_comb begin
    case (event_spin)
      SPIN_T:      spin_raw = T_SPIN_BONUS[idx];
      SPIN_T_MINI: spin_raw = MINI_SPIN_BONUS[idx];
      SPIN_S,
      SPIN_Z,
      SPIN_J,
      SPIN_L:      spin_raw = SZJL_SPIN_BONUS[idx];
      SPIN_I:      spin_raw = I_SPIN_BONUS[idx];
      default:     spin_raw = '0;
    endcase
  end

  // Max 19200 + 500 + 25600, fits 16 bits
  assign points = base + streak_bonus + spin_raw * POINTS_W'(mult);

endmodule

// ==== hw/bin_to_bcd.sv ====
module bin_to_bcd import score_pkg::*; (
  input  logic [POINTS_W-1:0]            points,
  output logic [4*BCD_DIGITS_POINTS-1:0] points_bcd
);

  localparam int BCD_W = 4*BCD_DIGITS_POINTS;

  logic [BCD_W-1:0] acc;

  // Shift-and-add-3, MSB first
  always_comb begin
    acc = '0;
    for (int i = POINTS_W-1; i >= 0; i--) begin
      for (int d = 0; d < BCD_DIGITS_POINTS; d++) begin
        if (acc[4*d +: 4] >= 4'd5)
          acc[4*d +: 4] = acc[4*d +: 4] + 4'd3; // Pre-correct before shift
      end
      acc = {acc[BCD_W-2:0], points[i]};
    end
  end

  assign points_bcd = acc;

endmodule

// ==== hw/bcd_score_acc.sv ====
module bcd_score_acc import score_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           clear,
  input  logic                           add_en,
  input  logic [4*BCD_DIGITS_POINTS-1:0] points_bcd,
  output logic [4*SCORE_DIGITS-1:0]      score
);

  localparam int SCORE_W = 4*SCORE_DIGITS;

  logic [SCORE_W-1:0] addend;
  logic [SCORE_W-1:0] sum;
  logic [4:0]         dsum;
  logic               carry;

  assign addend = {{(SCORE_W-4*BCD_DIGITS_POINTS){1'b0}}, points_bcd};

  // Decimal ripple add, digit by digit
  always_comb begin
    sum   = '0;
    carry = 1'b0;
    for (int i = 0; i < SCORE_DIGITS; i++) begin
      dsum = {1'b0, score[4*i +: 4]} + {1'b0, addend[4*i +: 4]} + {4'd0, carry};
      if (dsum >= 5'd10) begin
        sum[4*i +: 4] = 4'(dsum - 5'd10);
        carry         = 1'b1;
      end else begin
        sum[4*i +: 4] = dsum[3:0];
        carry         = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear)
      score <= '0;
    else if (add_en)
      score <= sum; // Top carry dropped, score wraps
  end

endmodule

// ==== hw/level_tracker.sv ====
module level_tracker import score_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clear,
  input  logic                     event_valid,
  input  logic [LINES_W-1:0]       event_lines,
  input  spin_t                    event_spin,
  output logic [TOTAL_LINES_W-1:0] total_lines,
  output logic [STREAK_W-1:0]      streak,
  output logic [LEVEL_W-1:0]       level,
  output logic [FRAMES_W-1:0]      drop_frames,
  output spin_t                    last_spin,
  output logic                     tetris
);

  logic [TOTAL_LINES_W-1:0] lvl_raw;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      total_lines <= '0;
      streak      <= '0;
      last_spin   <= SPIN_NONE;
      tetris      <= 1'b0;
    end else if (event_valid) begin
      total_lines <= total_lines + TOTAL_LINES_W'(event_lines); // Wraps at 256
      if (event_lines != '0) begin
        if (streak != STREAK_W'(STREAK_MAX))
          streak <= streak + 1'b1;
      end else begin
        streak <= '0; // Dry lock breaks the chain
      end
      last_spin <= event_spin;
      tetris    <= (event_lines == LINES_W'(MAX_LINES));
    end
  end

  // ====================
  // Level and gravity
  always_comb begin
    lvl_raw = TOTAL_LINES_W'(total_lines / LINES_PER_LEVEL);
    if (lvl_raw > TOTAL_LINES_W'(LEVEL_MAX))
      level = LEVEL_W'(LEVEL_MAX);
    else
      level = lvl_raw[LEVEL_W-1:0];
    drop_frames = DROP_FRAMES[level];
  end

endmodule

// ==== hw/score_unit.sv ====
module score_unit import score_pkg::*, apb_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [DATA_W-1:0] pwdata,
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  logic                           event_valid;
  logic [LINES_W-1:0]             event_lines;
  spin_t                          event_spin;
  logic                           clear;
  logic                           add_en;
  logic [POINTS_W-1:0]            points;
  logic [4*BCD_DIGITS_POINTS-1:0] points_bcd;
  logic [4*SCORE_DIGITS-1:0]      score;
  logic [TOTAL_LINES_W-1:0]       total_lines;
  logic [STREAK_W-1:0]            streak;
  logic [LEVEL_W-1:0]             level;
  logic [FRAMES_W-1:0]            drop_frames;
  spin_t                          last_spin;
  logic                           tetris;

  assign add_en = event_valid & (event_lines != '0); // Score only moves on a clear

  lock_apb_regs u_regs (
    .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .score, .total_lines, .streak, .level, .drop_frames, .last_spin, .tetris,
    .event_valid, .event_lines, .event_spin, .clear
  );

  points_calc u_points (.event_lines, .event_spin, .level, .streak, .points);

  bin_to_bcd u_bcd (.points, .points_bcd);

  bcd_score_acc u_score (.clk, .rst, .clear, .add_en, .points_bcd, .score);

  level_tracker u_level (
    .clk, .rst, .clear, .event_valid, .event_lines, .event_spin,
    .total_lines, .streak, .level, .drop_frames, .last_spin, .tetris
  );

endmodule

// ==== bench/score_unit_assertions.sv ====
module score_unit_assertions import score_pkg::*; (
  input logic                      clk,
  input logic                      rst,
  input logic                      psel,
  input logic                      penable,
  input logic                      pready,
  input logic                      pslverr,
  input logic                      event_valid,
  input logic [4*SCORE_DIGITS-1:0] score,
  input logic [TOTAL_LINES_W-1:0]  total_lines,
  input logic [LEVEL_W-1:0]        level
);

  pready_high: assert property (@(posedge clk) disable iff (rst) pready)
    else $error("pready went low");

  // Error response only inside an access phase
  slverr_in_access: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> (psel && penable))
    else $error("pslverr high outside an access phase");

  event_single_pulse: assert property (@(posedge clk) disable iff (rst)
    event_valid |=> !event_valid)
    else $error("event_valid held for two cycles");

  // Level never runs ahead of the line total
  level_in_range: assert property (@(posedge clk) disable iff (rst)
    (int'(level) * LINES_PER_LEVEL) <= int'(total_lines))
    else $error("level above what the line total allows");

  for (genvar i = 0; i < SCORE_DIGITS; i++) begin : g_digit
    digit_is_bcd: assert property (@(posedge clk) disable iff (rst)
      score[4*i +: 4] <= 4'd9)
      else $error("score digit %0d is not a decimal digit", i);
  end

endmodule

bind score_unit score_unit_assertions u_assertions (
  .clk, .rst, .psel, .penable, .pready, .pslverr, .event_valid, .score, .total_lines,
  .level
);

// ==== bench/tb_score_unit.sv ====
module tb_score_unit import apb_pkg::*; ();

  localparam int READY_TIMEOUT = 16; // Cycles
  localparam int DRIVE_DELAY   = 10;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;
  int                n_tests;
  int                n_fail;
  logic              timed_out;

  score_unit UUT (
    .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr
  );

  always #50 clk = ~clk;

  // ====================
  // APB master
  task automatic start_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata);
    @(posedge clk);
    #DRIVE_DELAY;
    psel    = 1'b1; // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DELAY;
    penable = 1'b1;
  endtask

  // Response sampled on the falling edge
  task automatic finish_transfer(output logic [DATA_W-1:0] rdata, output logic err);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    while (!seen && waited < READY_TIMEOUT) begin
      @(negedge clk);
      if (pready) begin
        seen  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end else begin
        waited++;
      end
    end
    if (!seen) begin
      $display("Timeout: pready stayed low for %0d cycles at address 0x%02h",
               READY_TIMEOUT, paddr);
      timed_out = 1'b1;
    end else begin
      @(posedge clk);
      #DRIVE_DELAY;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output logic err);
    logic [DATA_W-1:0] rd_ignored;
    start_transfer(1'b1, addr, data);
    finish_transfer(rd_ignored, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    start_transfer(1'b0, addr, '0);
    finish_transfer(data, err);
  endtask

  // ====================
  // One line of test data
  task automatic run_test(input string name, input string op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic exp_err);
    logic [DATA_W-1:0] got;
    logic              err;
    logic              ok;
    ok  = 1'b1;
    got = '0;
    if (op == "W")
      apb_write(addr, data, err);
    else
      apb_read(addr, got, err);
    if (timed_out) begin
      ok = 1'b0;
    end else begin
      assert (err == exp_err) else begin
        $display("ERROR %s: pslverr expected %0b, actual %0b", name, exp_err, err);
        ok = 1'b0;
      end
      if (op != "W") begin
        assert (got == data) else begin
          $display("ERROR %s: prdata expected 0x%08h, actual 0x%08h", name, data, got);
          ok = 1'b0;
        end
      end
    end
    n_tests++;
    if (ok) begin
      $display("PASS %s", name);
    end else begin
      n_fail++;
      $display("FAIL %s", name);
    end
  endtask

  initial begin
    int                fd;
    int                n;
    string             line;
    string             name;
    string             op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              exp_err;
    clk       = 1'b0;
    rst       = 1'b1;
    paddr     = REG_EVENT;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    n_tests   = 0;
    n_fail    = 0;
    timed_out = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    fd = $fopen("bench/score_unit_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file bench/score_unit_testdata.txt");
      $display("Test failures found");
      $finish;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin // Skip column notes
          n = $sscanf(line, "%s %s %h %h %b", name, op, addr, data, exp_err);
          if (n == 5)
            run_test(name, op, addr, data, exp_err);
        end
      end
      $fclose(fd);
      $display("Tests run: %0d, passed: %0d, failed: %0d", n_tests, n_tests - n_fail, n_fail);
      if (n_fail == 0 && n_tests > 0 && !timed_out)
        $display("All tests passed!");
      else
        $display("Test failures found");
      $finish;
    end
  end

endmodule

// ==== score_unit.f ====
hw/score_pkg.sv
hw/apb_pkg.sv
hw/lock_apb_regs.sv
hw/points_calc.sv
hw/bin_to_bcd.sv
hw/bcd_score_acc.sv
hw/level_tracker.sv
hw/score_unit.sv
bench/score_unit_assertions.sv
bench/tb_score_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the score_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_score_unit -f score_unit.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_score_unit 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
  exit 0
else
  exit 1
fi

// ==== bench/score_unit_testdata.txt ====
# name op(W/R) addr(hex) data(hex, write data or expected read data) pslverr
# Reads compare prdata and pslverr, writes compare pslverr only
reset_score     R 04 00000000 0
reset_lines     R 08 00000000 0
reset_level     R 0C 00002800 0
reset_flags     R 10 00000000 0
single_line     W 00 00000001 0
tetris_streak   W 00 00000004 0
score_1340      R 04 00001340 0
lines_5_str2    R 08 00000205 0
flags_tetris    R 10 00000010 0
tspin_no_lines  W 00 00000010 0
score_kept      R 04 00001340 0
streak_reset    R 08 00000005 0
flags_tspin     R 10 00000001 0
mini_single     W 00 00000021 0
s_single        W 00 00000031 0
z_double        W 00 00000042 0
score_spins     R 04 00003220 0
flags_z         R 10 00000004 0
j_single        W 00 00000051 0
score_j         R 04 00003960 0
level_1         R 0C 00002501 0
l_triple_lv1    W 00 00000063 0
i_tetris_lv1    W 00 00000074 0
score_carry     R 04 00013460 0
flags_i_tetris  R 10 00000017 0
single_capped   W 00 00000001 0
score_ripple    R 04 00014040 0
lines_18_str7   R 08 00000712 0
unmapped_write  W 18 00000001 1
score_ro_write  W 04 12345678 1
event_wo_read   R 00 00000000 1
event_5_lines   W 00 00000005 1
score_unchanged R 04 00014040 0
lines_unchanged R 08 00000712 0
clear_game      W 14 00000000 0
clear_score     R 04 00000000 0
clear_lines     R 08 00000000 0
clear_level     R 0C 00002800 0
clear_flags     R 10 00000000 0
